// File: gpio_block.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module gpio_block (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  wb_reg_if.block    bus_i,
  input  logic [3:0] gpio_i,
  output logic [3:0] gpio_o,
  output logic       irq_o
);

  sysctl_pkg::gpio_reg_e reg_sel;
  logic                  wr;
  logic [3:0]            edge_en;
  logic [3:0]            sync_meta;
  logic [3:0]            sync_q;
  logic [3:0]            prev_q;

  assign reg_sel = sysctl_pkg::gpio_reg_e'(bus_i.adr);
  assign wr      = bus_i.stb & bus_i.we;

  always_comb begin
    bus_i.rdata = '0;
    case (reg_sel)
      sysctl_pkg::GPIO_OUT:     bus_i.rdata[3:0] = gpio_o;
      sysctl_pkg::GPIO_IN:      bus_i.rdata[3:0] = sync_q;
      sysctl_pkg::GPIO_EDGE_EN: bus_i.rdata[3:0] = edge_en;
      default:                  bus_i.rdata = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      gpio_o    <= 4'b0;
      edge_en   <= 4'b0;
      sync_meta <= 4'b0;
      sync_q    <= 4'b0;
      prev_q    <= 4'b0;
      irq_o     <= 1'b0;
    end else begin
      sync_meta <= gpio_i;
      sync_q    <= sync_meta;
      prev_q    <= sync_q;
      // Pulse once per rising edge on any enabled input.
      irq_o     <= |(sync_q & ~prev_q & edge_en);
      if (wr && reg_sel == sysctl_pkg::GPIO_OUT) begin
        gpio_o <= bus_i.wdata[3:0];
      end
      if (wr && reg_sel == sysctl_pkg::GPIO_EDGE_EN) begin
        edge_en <= bus_i.wdata[3:0];
      end
    end
  end

endmodule

// File: interval_timer.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module interval_timer (
  input  logic    wb_clk_i,
  input  logic    wb_rst_i,
  wb_reg_if.block bus_i,
  output logic    irq_o
);

  sysctl_pkg::tmr_reg_e  reg_sel;
  logic                  wr;
  logic                  enable;
  logic                  periodic;
  logic                  tick;
  logic [`SYSCTL_TW-1:0] reload;
  logic [`SYSCTL_TW-1:0] prescale;
  logic [`SYSCTL_TW-1:0] pre_cnt;
  logic [`SYSCTL_TW-1:0] count;

  assign reg_sel = sysctl_pkg::tmr_reg_e'(bus_i.adr);
  assign wr      = bus_i.stb & bus_i.we;
  assign tick    = enable && (pre_cnt == prescale);

  always_comb begin
    bus_i.rdata = '0;
    case (reg_sel)
      sysctl_pkg::TMR_CTRL:     bus_i.rdata[1:0] = {periodic, enable};
      sysctl_pkg::TMR_RELOAD:   bus_i.rdata[`SYSCTL_TW-1:0] = reload;
      sysctl_pkg::TMR_PRESCALE: bus_i.rdata[`SYSCTL_TW-1:0] = prescale;
      sysctl_pkg::TMR_COUNT:    bus_i.rdata[`SYSCTL_TW-1:0] = count;
      default:                  bus_i.rdata = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      enable   <= 1'b0;
      periodic <= 1'b0;
      reload   <= '0;
      prescale <= '0;
      pre_cnt  <= '0;
      count    <= '0;
      irq_o    <= 1'b0;
    end else begin
      irq_o <= 1'b0;
      if (enable) begin
        pre_cnt <= tick ? '0 : pre_cnt + 1'b1;
      end
      if (tick) begin
        if (count == '0) begin
          irq_o <= 1'b1;
          if (periodic) begin
            count <= reload;
          end else begin
            enable <= 1'b0;
          end
        end else begin
          count <= count - 1'b1;
        end
      end
      if (wr && reg_sel == sysctl_pkg::TMR_RELOAD) begin
        reload <= bus_i.wdata[`SYSCTL_TW-1:0];
      end
      if (wr && reg_sel == sysctl_pkg::TMR_PRESCALE) begin
        prescale <= bus_i.wdata[`SYSCTL_TW-1:0];
      end
      // A control write wins over a tick in the same cycle.
      if (wr && reg_sel == sysctl_pkg::TMR_CTRL) begin
        enable   <= bus_i.wdata[0];
        periodic <= bus_i.wdata[1];
        if (bus_i.wdata[0]) begin
          count   <= reload;
          pre_cnt <= '0;
        end
      end
    end
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_sysctl -f sysctl.f -o tb_sysctl
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sysctl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx '>>> PASS' "$LOG"; then
  exit 0
else
  echo "pass line not found in $LOG"
  exit 1
fi

// File: sysctl.f
+incdir+.
sysctl_pkg.sv
wb_reg_if.sv
wb_region_decoder.sv
system_block.sv
interval_timer.sv
gpio_block.sv
sysctl_top.sv
tb_sysctl.sv

// File: sysctl_macros.svh
`ifndef SYSCTL_MACROS_SVH
`define SYSCTL_MACROS_SVH

// Identification values reported by the system block.
`define SYSCTL_DESIGN_ID 16'h5C17
`define SYSCTL_REV_MAJOR 8'd1
`define SYSCTL_REV_MINOR 8'd3
`define SYSCTL_REV_RCS   16'h0042

// Bus data width.
`define SYSCTL_DW 8

// Top-level address width and per-block register offset width.
`define SYSCTL_AW 5
`define SYSCTL_RW 3

// Interval timer counter width.
`define SYSCTL_TW 8

`endif

// File: sysctl_pkg.sv
`include "sysctl_macros.svh"

package sysctl_pkg;

  // Upper address bits select one of four regions.
  typedef enum logic [`SYSCTL_AW-`SYSCTL_RW-1:0] {
    REG_SYS  = 2'd0,
    REG_TMR  = 2'd1,
    REG_GPIO = 2'd2,
    REG_NONE = 2'd3
  } region_e;

  typedef enum logic [`SYSCTL_RW-1:0] {
    ID_HI, ID_LO, MAJ, MIN, RCS_HI, RCS_LO, IRQ_MASK, IRQ_RAISED
  } sys_reg_e;

  typedef enum logic [`SYSCTL_RW-1:0] {
    TMR_CTRL = 3'd0, TMR_RELOAD = 3'd1, TMR_PRESCALE = 3'd2, TMR_COUNT = 3'd3
  } tmr_reg_e;

  typedef enum logic [`SYSCTL_RW-1:0] {
    GPIO_OUT = 3'd0, GPIO_IN = 3'd1, GPIO_EDGE_EN = 3'd2
  } gpio_reg_e;

endpackage

// File: sysctl_top.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module sysctl_top (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`SYSCTL_AW-1:0] wb_adr_i,
  input  logic [`SYSCTL_DW-1:0] wb_dat_i,
  output logic [`SYSCTL_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  input  logic [3:0]            gpio_i,
  output logic [3:0]            gpio_o,
  input  logic [1:0]            ext_irq_i,
  output logic                  irq_o
);

  wb_reg_if sys_bus ();
  wb_reg_if tmr_bus ();
  wb_reg_if gpio_bus ();

  logic tmr_irq;
  logic gpio_irq;

  wb_region_decoder u_decoder (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .sys_o    (sys_bus.decoder),
    .tmr_o    (tmr_bus.decoder),
    .gpio_o   (gpio_bus.decoder)
  );

  // Interrupt sources: timer, GPIO edge, then the two external pins.
  system_block #(
    .DESIGN_ID (`SYSCTL_DESIGN_ID),
    .REV_MAJOR (`SYSCTL_REV_MAJOR),
    .REV_MINOR (`SYSCTL_REV_MINOR),
    .REV_RCS   (`SYSCTL_REV_RCS)
  ) u_system (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .bus_i     (sys_bus.block),
    .irq_src_i ({ext_irq_i, gpio_irq, tmr_irq}),
    .irq_o     (irq_o)
  );

  interval_timer u_timer (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus_i    (tmr_bus.block),
    .irq_o    (tmr_irq)
  );

  gpio_block u_gpio (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .bus_i    (gpio_bus.block),
    .gpio_i   (gpio_i),
    .gpio_o   (gpio_o),
    .irq_o    (gpio_irq)
  );

endmodule

// File: system_block.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module system_block #(
  parameter logic [15:0] DESIGN_ID = 16'h0000,
  parameter logic [7:0]  REV_MAJOR = 8'h00,
  parameter logic [7:0]  REV_MINOR = 8'h00,
  parameter logic [15:0] REV_RCS   = 16'h0000
) (
  input  logic       wb_clk_i,
  input  logic       wb_rst_i,
  wb_reg_if.block    bus_i,
  input  logic [3:0] irq_src_i,
  output logic       irq_o
);

  sysctl_pkg::sys_reg_e reg_sel;
  logic                 wr;
  logic [3:0]           irq_mask;
  logic [3:0]           irq_raised;

  assign reg_sel = sysctl_pkg::sys_reg_e'(bus_i.adr);
  assign wr      = bus_i.stb & bus_i.we;

  always_comb begin
    bus_i.rdata = '0;
    case (reg_sel)
      sysctl_pkg::ID_HI: begin
        bus_i.rdata[7:0] = DESIGN_ID[15:8];
      end
      sysctl_pkg::ID_LO: begin
        bus_i.rdata[7:0] = DESIGN_ID[7:0];
      end
      sysctl_pkg::MAJ: begin
        bus_i.rdata[7:0] = REV_MAJOR;
      end
      sysctl_pkg::MIN: begin
        bus_i.rdata[7:0] = REV_MINOR;
      end
      sysctl_pkg::RCS_HI: begin
        bus_i.rdata[7:0] = REV_RCS[15:8];
      end
      sysctl_pkg::RCS_LO: begin
        bus_i.rdata[7:0] = REV_RCS[7:0];
      end
      sysctl_pkg::IRQ_MASK: begin
        bus_i.rdata[3:0] = irq_mask;
      end
      default: begin
        bus_i.rdata[3:0] = irq_raised;
      end
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      irq_mask   <= 4'b0;
      irq_raised <= 4'b0;
    end else begin
      // Sources accumulate every cycle. A bus write overrides them, so
      // writing zero acknowledges everything that has been raised.
      irq_raised <= irq_raised | irq_src_i;
      if (wr && reg_sel == sysctl_pkg::IRQ_RAISED) begin
        irq_raised <= bus_i.wdata[3:0];
      end
      if (wr && reg_sel == sysctl_pkg::IRQ_MASK) begin
        irq_mask <= bus_i.wdata[3:0];
      end
    end
  end

  assign irq_o = |(irq_raised & irq_mask);

endmodule

// File: tb_sysctl.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module tb_sysctl;

  localparam int          ACK_LIMIT  = 8;
  localparam int          POLL_LIMIT = 100;
  localparam logic [15:0] DESIGN_ID  = `SYSCTL_DESIGN_ID;
  localparam logic [15:0] REV_RCS    = `SYSCTL_REV_RCS;

  logic                  wb_clk_i;
  logic                  wb_rst_i;
  logic                  wb_cyc_i;
  logic                  wb_stb_i;
  logic                  wb_we_i;
  logic [`SYSCTL_AW-1:0] wb_adr_i;
  logic [`SYSCTL_DW-1:0] wb_dat_i;
  logic [`SYSCTL_DW-1:0] wb_dat_o;
  logic                  wb_ack_o;
  logic [3:0]            gpio_i;
  logic [3:0]            gpio_o;
  logic [1:0]            ext_irq_i;
  logic                  irq_o;

  // Model of the writable registers.
  logic [3:0] m_mask;
  logic [3:0] m_raised;
  logic [3:0] m_gpio_out;
  logic [3:0] m_edge_en;
  logic [7:0] m_reload;
  logic [7:0] m_prescale;

  sysctl_top u_dut (.*);

  initial wb_clk_i = 1'b0;
  always #4 wb_clk_i = ~wb_clk_i;

  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("error: %s is 0x%h, expected 0x%h", name, got, exp);
      stop_with_failure();
    end
  endtask

  function automatic logic [4:0] reg_addr(input sysctl_pkg::region_e region,
                                          input logic [2:0] offset);
    return {region, offset};
  endfunction

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge wb_clk_i);
      #1;
    end
  endtask

  // Entered and left 1 ns after a rising edge.
  task automatic bus_access(input logic we, input logic [4:0] adr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
    int   cycles;
    logic got_ack;
    cycles   = 0;
    got_ack  = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    while (!got_ack && cycles < ACK_LIMIT) begin
      @(posedge wb_clk_i);
      #1;
      cycles++;
      got_ack = wb_ack_o;
    end
    if (!got_ack) begin
      $display("timeout: the DUT gave no ack within %0d cycles", ACK_LIMIT);
      stop_with_failure();
    end
    check_value("wb_ack_o latency", 8'(cycles), 8'd1);
    rdata = wb_dat_o;
    // The request stays on the bus through the ack cycle, when the block commits.
    @(posedge wb_clk_i);
    #1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    check_value("wb_ack_o", {7'b0, wb_ack_o}, 8'h00);
  endtask

  task automatic bus_write(input logic [4:0] adr, input logic [7:0] wdata);
    logic [7:0] unused;
    bus_access(1'b1, adr, wdata, unused);
  endtask

  task automatic bus_read(input logic [4:0] adr, output logic [7:0] rdata);
    bus_access(1'b0, adr, 8'h00, rdata);
  endtask

  task automatic write_and_verify(input logic [4:0] adr, input logic [7:0] wdata,
                                  input logic [7:0] exp, input string name);
    logic [7:0] data;
    bus_write(adr, wdata);
    bus_read(adr, data);
    check_value(name, data, exp);
  endtask

  // Reads a register until the masked bits match, or gives up.
  task automatic poll_until(input logic [4:0] adr, input logic [7:0] mask,
                            input logic [7:0] exp, input string what);
    int         polls;
    logic [7:0] data;
    polls = 0;
    bus_read(adr, data);
    while (((data & mask) != exp) && polls < POLL_LIMIT) begin
      bus_read(adr, data);
      polls++;
    end
    if ((data & mask) != exp) begin
      $display("timeout: %s did not happen within %0d reads", what, POLL_LIMIT);
      stop_with_failure();
    end
  endtask

  task automatic check_irq_line();
    check_value("irq_o", {7'b0, irq_o}, {7'b0, |(m_raised & m_mask)});
  endtask

  task automatic pulse_ext_irq(input logic [1:0] pins);
    ext_irq_i = pins;
    wait_cycles(1);
    ext_irq_i = 2'b00;
  endtask

  initial begin
    logic [7:0] data;
    logic [7:0] value;
    logic [1:0] pins;
    int         b;
    int         d;
    void'($urandom(53));
    wb_rst_i   = 1'b1;
    wb_cyc_i   = 1'b0;
    wb_stb_i   = 1'b0;
    wb_we_i    = 1'b0;
    wb_adr_i   = '0;
    wb_dat_i   = '0;
    gpio_i     = 4'h0;
    ext_irq_i  = 2'b00;
    m_mask     = 4'h0;
    m_raised   = 4'h0;
    m_gpio_out = 4'h0;
    m_edge_en  = 4'h0;
    m_reload   = 8'h00;
    m_prescale = 8'h00;
    repeat (16) @(posedge wb_clk_i);
    #1;
    wb_rst_i = 1'b0;
    check_irq_line();

    // Identification bytes, then the unmapped region.
    bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::ID_HI), data);
    check_value("wb_dat_o[ID_HI]", data, DESIGN_ID[15:8]);
    bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::ID_LO), data);
    check_value("wb_dat_o[ID_LO]", data, DESIGN_ID[7:0]);
    bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::MAJ), data);
    check_value("wb_dat_o[MAJ]", data, `SYSCTL_REV_MAJOR);
    bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::MIN), data);
    check_value("wb_dat_o[MIN]", data, `SYSCTL_REV_MINOR);
    bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::RCS_HI), data);
    check_value("wb_dat_o[RCS_HI]", data, REV_RCS[15:8]);
    bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::RCS_LO), data);
    check_value("wb_dat_o[RCS_LO]", data, REV_RCS[7:0]);
    for (int i = 0; i < 8; i++) begin
      bus_write(reg_addr(sysctl_pkg::REG_NONE, 3'($urandom)), 8'($urandom));
      bus_read(reg_addr(sysctl_pkg::REG_NONE, 3'($urandom)), data);
      check_value("wb_dat_o[REG_NONE]", data, 8'h00);
    end

    // Read right after write, masked to the implemented bits.
    for (int i = 0; i < 8; i++) begin
      value  = 8'($urandom);
      m_mask = value[3:0];
      write_and_verify(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_MASK), value,
                       {4'h0, m_mask}, "wb_dat_o[IRQ_MASK]");
      value    = 8'($urandom);
      m_reload = value;
      write_and_verify(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_RELOAD), value,
                       m_reload, "wb_dat_o[TMR_RELOAD]");
      value      = 8'($urandom);
      m_prescale = value;
      write_and_verify(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_PRESCALE), value,
                       m_prescale, "wb_dat_o[TMR_PRESCALE]");
      value     = 8'($urandom);
      m_edge_en = value[3:0];
      write_and_verify(reg_addr(sysctl_pkg::REG_GPIO, sysctl_pkg::GPIO_EDGE_EN), value,
                       {4'h0, m_edge_en}, "wb_dat_o[GPIO_EDGE_EN]");
    end

    // External interrupt pins against the sticky model.
    for (int i = 0; i < 24; i++) begin
      pins = 2'($urandom);
      pulse_ext_irq(pins);
      m_raised = m_raised | {pins, 2'b00};
      if ($urandom_range(0, 2) == 0) begin
        value  = 8'($urandom);
        m_mask = value[3:0];
        bus_write(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_MASK), value);
      end
      bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), data);
      check_value("wb_dat_o[IRQ_RAISED]", data, {4'h0, m_raised});
      check_irq_line();
      if ($urandom_range(0, 3) == 0) begin
        // A pin that stays high across the clear sets its bit again.
        pins      = 2'($urandom);
        ext_irq_i = pins;
        bus_write(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h00);
        wait_cycles(1);
        ext_irq_i = 2'b00;
        m_raised  = {pins, 2'b00};
        bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), data);
        check_value("wb_dat_o[IRQ_RAISED]", data, {4'h0, m_raised});
        check_irq_line();
      end
    end

    // GPIO outputs and synchronized inputs with edge detection off.
    m_edge_en = 4'h0;
    bus_write(reg_addr(sysctl_pkg::REG_GPIO, sysctl_pkg::GPIO_EDGE_EN), 8'h00);
    for (int i = 0; i < 8; i++) begin
      value      = 8'($urandom);
      m_gpio_out = value[3:0];
      write_and_verify(reg_addr(sysctl_pkg::REG_GPIO, sysctl_pkg::GPIO_OUT), value,
                       {4'h0, m_gpio_out}, "wb_dat_o[GPIO_OUT]");
      check_value("gpio_o", {4'h0, gpio_o}, {4'h0, m_gpio_out});
      gpio_i = 4'($urandom);
      poll_until(reg_addr(sysctl_pkg::REG_GPIO, sysctl_pkg::GPIO_IN), 8'hFF,
                 {4'h0, gpio_i}, "GPIO_IN update");
    end

    // Rising edges on a disabled bit and then on an enabled bit.
    for (int i = 0; i < 4; i++) begin
      gpio_i = 4'h0;
      poll_until(reg_addr(sysctl_pkg::REG_GPIO, sysctl_pkg::GPIO_IN), 8'hFF, 8'h00,
                 "GPIO_IN clear");
      wait_cycles(3);
      m_raised = 4'h0;
      bus_write(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h00);
      b        = $urandom_range(0, 3);
      d        = (b + $urandom_range(1, 3)) % 4;
      value    = 8'($urandom);
      value[b] = 1'b1;
      value[d] = 1'b0;
      m_edge_en = value[3:0];
      bus_write(reg_addr(sysctl_pkg::REG_GPIO, sysctl_pkg::GPIO_EDGE_EN), value);
      gpio_i[d] = 1'b1;
      poll_until(reg_addr(sysctl_pkg::REG_GPIO, sysctl_pkg::GPIO_IN), 8'hFF,
                 {4'h0, gpio_i}, "GPIO_IN update");
      wait_cycles(4);
      bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), data);
      check_value("wb_dat_o[IRQ_RAISED]", data, 8'h00);
      gpio_i[b] = 1'b1;
      poll_until(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h02, 8'h02,
                 "GPIO edge interrupt");
      m_raised = 4'b0010;
      check_irq_line();
    end

    // Timer in one-shot mode, then in periodic mode.
    for (int i = 0; i < 3; i++) begin
      bus_write(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_CTRL), 8'h00);
      m_raised = 4'h0;
      bus_write(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h00);
      m_reload   = 8'($urandom_range(0, 6));
      m_prescale = 8'($urandom_range(0, 3));
      bus_write(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_RELOAD), m_reload);
      bus_write(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_PRESCALE), m_prescale);
      bus_write(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_CTRL), 8'h01);
      poll_until(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h01, 8'h01,
                 "one-shot timer interrupt");
      bus_read(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_CTRL), data);
      check_value("wb_dat_o[TMR_CTRL]", data, 8'h00);
      bus_write(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_CTRL), 8'h03);
      poll_until(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h01, 8'h01,
                 "first periodic timer interrupt");
      bus_write(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h00);
      poll_until(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h01, 8'h01,
                 "repeated periodic timer interrupt");
      bus_read(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_CTRL), data);
      check_value("wb_dat_o[TMR_CTRL]", data, 8'h03);
    end
    bus_write(reg_addr(sysctl_pkg::REG_TMR, sysctl_pkg::TMR_CTRL), 8'h00);
    m_raised = 4'h0;
    bus_write(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), 8'h00);
    bus_read(reg_addr(sysctl_pkg::REG_SYS, sysctl_pkg::IRQ_RAISED), data);
    check_value("wb_dat_o[IRQ_RAISED]", data, {4'h0, m_raised});
    check_irq_line();

    $display(">>> PASS");
    $finish;
  end

endmodule

// File: wb_reg_if.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

// Register port between the region decoder and one register block.
interface wb_reg_if;

  logic                   stb;
  logic                   we;
  logic [`SYSCTL_RW-1:0]  adr;
  logic [`SYSCTL_DW-1:0]  wdata;
  logic [`SYSCTL_DW-1:0]  rdata;

  modport decoder (
    output stb,
    output we,
    output adr,
    output wdata,
    input  rdata
  );

  // The block answers rdata combinationally from adr.
  modport block (
    input  stb,
    input  we,
    input  adr,
    input  wdata,
    output rdata
  );

endinterface

// File: wb_region_decoder.sv
`timescale 1ns/1ps
`include "sysctl_macros.svh"

module wb_region_decoder (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`SYSCTL_AW-1:0] wb_adr_i,
  input  logic [`SYSCTL_DW-1:0] wb_dat_i,
  output logic [`SYSCTL_DW-1:0] wb_dat_o,
  output logic                  wb_ack_o,
  wb_reg_if.decoder             sys_o,
  wb_reg_if.decoder             tmr_o,
  wb_reg_if.decoder             gpio_o
);

  sysctl_pkg::region_e   region;
  logic                  req;
  logic [`SYSCTL_DW-1:0] rdata_sel;

  assign region = sysctl_pkg::region_e'(wb_adr_i[`SYSCTL_AW-1:`SYSCTL_RW]);

  // A request still held during its ack cycle is not taken a second time.
  assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_comb begin
    case (region)
      sysctl_pkg::REG_SYS:  rdata_sel = sys_o.rdata;
      sysctl_pkg::REG_TMR:  rdata_sel = tmr_o.rdata;
      sysctl_pkg::REG_GPIO: rdata_sel = gpio_o.rdata;
      default:              rdata_sel = '0;
    endcase
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      sys_o.stb  <= 1'b0;
      tmr_o.stb  <= 1'b0;
      gpio_o.stb <= 1'b0;
    end else begin
      wb_ack_o   <= req;
      sys_o.stb  <= req && (region == sysctl_pkg::REG_SYS);
      tmr_o.stb  <= req && (region == sysctl_pkg::REG_TMR);
      gpio_o.stb <= req && (region == sysctl_pkg::REG_GPIO);
    end
  end

  // Read data is sampled before the block commits any write.
  always_ff @(posedge wb_clk_i) begin
    if (req) begin
      wb_dat_o <= rdata_sel;
    end
  end

  // The master holds offset, data and direction through the ack cycle.
  assign sys_o.adr    = wb_adr_i[`SYSCTL_RW-1:0];
  assign sys_o.we     = wb_we_i;
  assign sys_o.wdata  = wb_dat_i;
  assign tmr_o.adr    = wb_adr_i[`SYSCTL_RW-1:0];
  assign tmr_o.we     = wb_we_i;
  assign tmr_o.wdata  = wb_dat_i;
  assign gpio_o.adr   = wb_adr_i[`SYSCTL_RW-1:0];
  assign gpio_o.we    = wb_we_i;
  assign gpio_o.wdata = wb_dat_i;

endmodule
